//--- common/box_cmd_pkg.sv
// box command package: rectangle draw command and the default box and clear commands
`default_nettype none

package box_cmd_pkg;
    import vga_geom_pkg::*;

    // one filled rectangle, origin at top left, 33 bits
    typedef struct packed {
        x_coord_t x;       // origin column
        y_coord_t y;       // origin row
        x_coord_t width;   // up to SCREEN_W
        y_coord_t height;  // up to SCREEN_H
        colour_t  colour;
    } rect_cmd_t;

    parameter int DEFAULT_BOX_SIZE = 4;  // box edge in pixels

    // full screen fill in black from the origin
    parameter rect_cmd_t CLEAR_CMD = '{x: '0, y: '0, width: x_coord_t'(SCREEN_W),
                                       height: y_coord_t'(SCREEN_H), colour: COLOUR_BLACK};

endpackage

`default_nettype wire

//--- common/draw_req_if.sv
// draw request interface: rectangle command from the button controller to the raster engine
`timescale 1ns/10ps
`default_nettype none

interface draw_req_if
    import box_cmd_pkg::*;
(
    input wire logic clk
);

    logic      start;  // single cycle strobe
    rect_cmd_t cmd;    // held from start until ready is back
    logic      ready;  // engine idle

    // controller side
    modport requester (
        input  clk,
        output start,
        output cmd,
        input  ready
    );

    // raster engine side
    modport engine (
        input  clk,
        input  start,
        input  cmd,
        output ready
    );

endinterface

`default_nettype wire

//--- common/vga_geom_pkg.sv
// vga geometry package: screen size, coordinate, colour and pixel types
`default_nettype none

package vga_geom_pkg;

    // visible frame buffer size in pixels
    parameter int SCREEN_W = 160;
    parameter int SCREEN_H = 120;

    typedef logic [7:0] x_coord_t;  // column, 0..159
    typedef logic [6:0] y_coord_t;  // row, 0..119
    typedef logic [2:0] colour_t;   // {r, g, b}

    parameter colour_t COLOUR_BLACK = 3'b000;

    // one pixel write as it leaves the raster engine, 18 bits
    typedef struct packed {
        x_coord_t x;
        y_coord_t y;
        colour_t  colour;
    } pixel_t;

endpackage

`default_nettype wire

//--- logic/box_cmd_ctrl.sv
// box command controller: turns button presses into box and clear rectangle requests
`timescale 1ns/10ps
`default_nettype none

module box_cmd_ctrl
    import vga_geom_pkg::*, box_cmd_pkg::*;
#(
    parameter int BOX_SIZE = DEFAULT_BOX_SIZE
)
(
    input  wire logic     clk,
    input  wire logic     resetn,
    input  wire logic     load_x,    // button levels, act on release
    input  wire logic     plot_box,
    input  wire logic     black,
    input  wire colour_t  colour_in,
    input  wire logic [6:0] xy_coord,  // switches, shared by x and y
    draw_req_if.requester req
);

    // highest y origin that keeps the whole box on screen
    localparam y_coord_t Y_MAX = y_coord_t'(SCREEN_H - BOX_SIZE);

    typedef enum logic [3:0] {
        S_IDLE,
        S_LOAD_X,        // latch x origin
        S_LOAD_X_WAIT,   // wait for load_x release
        S_LOAD_Y,        // wait for plot_box press
        S_LOAD_Y_WAIT,   // wait for plot_box release
        S_BLACK,         // load the clear command
        S_BLACK_WAIT,    // wait for black release
        S_ISSUE,         // start strobe
        S_WAIT_READY     // engine busy, buttons ignored
    } state_t;

    state_t    state, next_state;
    rect_cmd_t cmd_q;      // command under construction, then held for the engine
    y_coord_t  y_clamped;

    // y origin from the switches, pulled down so the box ends on row 119 at most
    assign y_clamped = (y_coord_t'(xy_coord) > Y_MAX) ? Y_MAX : y_coord_t'(xy_coord);

    // next state
    always_comb
    begin
        next_state = state;
        case (state)
            S_IDLE:
            begin
                if (black)
                    next_state = S_BLACK;   // clear wins over a box
                else if (load_x)
                    next_state = S_LOAD_X;
            end
            S_LOAD_X:      next_state = S_LOAD_X_WAIT;
            S_LOAD_X_WAIT: next_state = load_x ? S_LOAD_X_WAIT : S_LOAD_Y;
            S_LOAD_Y:      next_state = plot_box ? S_LOAD_Y_WAIT : S_LOAD_Y;
            S_LOAD_Y_WAIT: next_state = plot_box ? S_LOAD_Y_WAIT : S_ISSUE;
            S_BLACK:       next_state = S_BLACK_WAIT;
            S_BLACK_WAIT:  next_state = black ? S_BLACK_WAIT : S_ISSUE;
            S_ISSUE:       next_state = S_WAIT_READY;
            // ready drops the cycle after start, so the first look here sees it low
            S_WAIT_READY:  next_state = req.ready ? S_IDLE : S_WAIT_READY;
            default:       next_state = S_IDLE;
        endcase
    end

    // state and command registers
    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            state <= S_IDLE;
            cmd_q <= '0;    // origin and size start at zero
        end
        else
        begin
            state <= next_state;
            case (state)
                S_LOAD_X: cmd_q.x <= {1'b0, xy_coord};  // only 7 switches, msb zero
                S_LOAD_Y:
                begin
                    if (plot_box)   // latch on the press, x stays as loaded
                    begin
                        cmd_q.y      <= y_clamped;
                        cmd_q.colour <= colour_in;
                        cmd_q.width  <= x_coord_t'(BOX_SIZE);
                        cmd_q.height <= y_coord_t'(BOX_SIZE);
                    end
                end
                S_BLACK: cmd_q <= CLEAR_CMD;    // whole screen, colour 0
                default:
                begin
                end
            endcase
        end
    end

    assign req.start = (state == S_ISSUE);  // one cycle after the release
    assign req.cmd   = cmd_q;               // stable until ready returns

endmodule

`default_nettype wire

//--- logic/box_plotter_top.sv
// box plotter top: button controller feeding the rectangle raster engine
`timescale 1ns/10ps
`default_nettype none

module box_plotter_top
    import vga_geom_pkg::*, box_cmd_pkg::*;
#(
    parameter int BOX_SIZE = DEFAULT_BOX_SIZE
)
(
    input  wire logic       clk,
    input  wire logic       resetn,
    input  wire logic       load_x,
    input  wire logic       plot_box,
    input  wire logic       black,
    input  wire colour_t    colour_in,
    input  wire logic [6:0] xy_coord,
    output logic            plot,
    output x_coord_t        x_out,
    output y_coord_t        y_out,
    output colour_t         colour_out
);

    pixel_t pixel;  // packed pixel from the engine

    draw_req_if draw_req (.clk(clk));

    box_cmd_ctrl #(
        .BOX_SIZE(BOX_SIZE)
    ) box_cmd_ctrl_i (
        .clk       (clk),
        .resetn    (resetn),
        .load_x    (load_x),
        .plot_box  (plot_box),
        .black     (black),
        .colour_in (colour_in),
        .xy_coord  (xy_coord),
        .req       (draw_req.requester)
    );

    rect_raster rect_raster_i (
        .clk    (clk),
        .resetn (resetn),
        .req    (draw_req.engine),
        .pixel  (pixel),
        .plot   (plot)
    );

    // split the pixel for the vga adapter
    assign x_out      = pixel.x;
    assign y_out      = pixel.y;
    assign colour_out = pixel.colour;

endmodule

`default_nettype wire

//--- raster/rect_raster.sv
// rectangle raster engine: sweeps a rectangle row by row, one pixel strobe per pixel
`timescale 1ns/10ps
`default_nettype none

module rect_raster
    import vga_geom_pkg::*, box_cmd_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   resetn,
    draw_req_if.engine  req,
    output pixel_t      pixel,   // registered pixel write
    output logic        plot     // one strobe per pixel
);

    typedef enum logic [1:0] {
        S_IDLE,     // ready high, waiting for start
        S_LOAD,     // end points and counters set up
        S_SWEEP,    // one pixel per cycle
        S_DONE      // last strobe on the output
    } state_t;

    state_t    state;
    rect_cmd_t cmd_q;              // command copy taken at start
    x_coord_t  last_x, cur_x;
    y_coord_t  last_y, cur_y;
    logic      row_end, last_pix;

    assign row_end  = (cur_x == last_x);
    assign last_pix = row_end && (cur_y == last_y);

    // control: state, output strobe and pixel register
    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            state <= S_IDLE;
            plot  <= 1'b0;
            pixel <= '0;
        end
        else
        begin
            plot <= 1'b0;
            case (state)
                S_IDLE:  state <= req.start ? S_LOAD : S_IDLE;
                S_LOAD:  state <= S_SWEEP;
                S_SWEEP:
                begin
                    plot  <= 1'b1;
                    pixel <= '{x: cur_x, y: cur_y, colour: cmd_q.colour};
                    if (last_pix)
                        state <= S_DONE;
                end
                S_DONE:  state <= S_IDLE;   // ready comes back next cycle
                default: state <= S_IDLE;
            endcase
        end
    end

    // datapath: command copy, end points and sweep counters
    always_ff @(posedge clk)
    begin
        case (state)
            S_IDLE:
            begin
                if (req.start)
                    cmd_q <= req.cmd;
            end
            S_LOAD:
            begin
                last_x <= cmd_q.x + cmd_q.width - 8'd1;    // 159 at most
                last_y <= cmd_q.y + cmd_q.height - 7'd1;   // 119 at most
                cur_x  <= cmd_q.x;
                cur_y  <= cmd_q.y;
            end
            S_SWEEP:
            begin
                if (row_end)
                begin
                    cur_x <= cmd_q.x;       // back to the left edge
                    cur_y <= cur_y + 7'd1;  // next row down
                end
                else
                    cur_x <= cur_x + 8'd1;
            end
            default:
            begin
            end
        endcase
    end

    assign req.ready = (state == S_IDLE);

endmodule

`default_nettype wire

//--- src.f
common/vga_geom_pkg.sv
common/box_cmd_pkg.sv
common/draw_req_if.sv
logic/box_cmd_ctrl.sv
raster/rect_raster.sv
logic/box_plotter_top.sv
tests/tb_box_plotter.sv

//--- tests/tb_box_plotter.sv
// box plotter testbench: table of box and clear commands checked against a pixel scoreboard
`timescale 1ns/10ps
`default_nettype none

module tb_box_plotter
    import vga_geom_pkg::*, box_cmd_pkg::*;
();

    localparam int NUM_ENTRIES        = 5;
    localparam int FIRST_PLOT_TIMEOUT = 20;  // cycles from release to first strobe
    localparam int PIXEL_TIMEOUT      = 4;   // gap allowed between strobes
    localparam int AFTER_WATCH        = 20;  // quiet cycles expected after a sweep
    localparam int RESET_WATCH        = 50;

    typedef enum logic {OP_BOX, OP_CLEAR} op_t;

    typedef struct packed {
        op_t        op;
        logic [6:0] x_sw;      // switch value for x
        logic [6:0] y_sw;      // switch value for y
        colour_t    colour;
        logic       disturb;   // press plot_box and black during the sweep
        rect_cmd_t  exp_rect;  // rectangle the sweep must cover
    } entry_t;

    logic       clk;
    logic       resetn;
    logic       load_x, plot_box, black;
    colour_t    colour_in;
    logic [6:0] xy_coord;
    logic       plot;
    x_coord_t   x_out;
    y_coord_t   y_out;
    colour_t    colour_out;

    entry_t entries [0:NUM_ENTRIES-1];
    int     error_count = 0;
    int     pass_count  = 0;
    int     fail_count  = 0;

    box_plotter_top box_plotter_top_i (
        .clk        (clk),
        .resetn     (resetn),
        .load_x     (load_x),
        .plot_box   (plot_box),
        .black      (black),
        .colour_in  (colour_in),
        .xy_coord   (xy_coord),
        .plot       (plot),
        .x_out      (x_out),
        .y_out      (y_out),
        .colour_out (colour_out)
    );

    always #5 clk = ~clk;  // 10 ns period

    function automatic entry_t make_entry(input op_t op, input int x_sw, input int y_sw,
                                          input int colour, input logic disturb, input int ex,
                                          input int ey, input int ew, input int eh, input int ec);
        entry_t e;
        e.op              = op;
        e.x_sw            = 7'(x_sw);
        e.y_sw            = 7'(y_sw);
        e.colour          = colour_t'(colour);
        e.disturb         = disturb;
        e.exp_rect.x      = x_coord_t'(ex);
        e.exp_rect.y      = y_coord_t'(ey);
        e.exp_rect.width  = x_coord_t'(ew);
        e.exp_rect.height = y_coord_t'(eh);
        e.exp_rect.colour = colour_t'(ec);
        return e;
    endfunction

    // nth pixel of a rectangle in row by row order
    function automatic pixel_t expected_pixel(input rect_cmd_t r, input int idx);
        pixel_t p;
        p.x      = r.x + x_coord_t'(idx % int'(r.width));
        p.y      = r.y + y_coord_t'(idx / int'(r.width));
        p.colour = r.colour;
        return p;
    endfunction

    task automatic check_pixel(input pixel_t got, input pixel_t exp, input int idx);
        if (got !== exp)
        begin
            $display("[ERROR] %0t ns: pixel %0d got (%0d,%0d,%0d), expected (%0d,%0d,%0d)",
                     $time, idx, got.x, got.y, got.colour, exp.x, exp.y, exp.colour);
            error_count++;
        end
    endtask

    task automatic check_count(input int got, input int exp);
        if (got != exp)
        begin
            $display("[ERROR] %0t ns: %0d pixel strobes seen, expected %0d", $time, got, exp);
            error_count++;
        end
    endtask

    task automatic press_box(input logic [6:0] x_sw, input logic [6:0] y_sw, input colour_t c);
        xy_coord = x_sw;
        load_x   = 1'b1;
        repeat (3) @(negedge clk);
        load_x = 1'b0;
        repeat (2) @(negedge clk);
        xy_coord  = y_sw;          // y and colour latch on the plot_box press
        colour_in = c;
        plot_box  = 1'b1;
        repeat (3) @(negedge clk);
        plot_box = 1'b0;           // release starts the box
    endtask

    task automatic press_clear(input logic [6:0] sw, input colour_t c);
        xy_coord  = sw;            // switches and colour must be ignored
        colour_in = c;
        black     = 1'b1;
        repeat (3) @(negedge clk);
        black = 1'b0;
    endtask

    task automatic wait_first_plot(output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < FIRST_PLOT_TIMEOUT)
        begin
            @(negedge clk);
            if (plot)
                seen = 1'b1;
            else
                cycles++;
        end
        if (!seen)
        begin
            $display("no pixel strobe within %0d cycles of the button release",
                     FIRST_PLOT_TIMEOUT);
            error_count++;
        end
    endtask

    // called on the negedge that shows the first strobe
    task automatic receive_pixels(input rect_cmd_t r, input logic disturb, output int got);
        int expected;
        int idle;
        bit stop;
        expected = int'(r.width) * int'(r.height);
        got      = 0;
        idle     = 0;
        stop     = 1'b0;
        while (got < expected && !stop)
        begin
            if (plot)
            begin
                check_pixel(pixel_t'{x: x_out, y: y_out, colour: colour_out},
                            expected_pixel(r, got), got);
                got++;
                idle = 0;
                if (disturb && got == 3)
                begin
                    plot_box = 1'b1;   // buttons while the engine is busy
                    black    = 1'b1;
                end
                if (disturb && got == 9)
                begin
                    plot_box = 1'b0;
                    black    = 1'b0;
                end
            end
            else
            begin
                idle++;
                if (idle > PIXEL_TIMEOUT)
                begin
                    $display("pixel %0d of %0d did not arrive within %0d cycles",
                             got, expected, PIXEL_TIMEOUT);
                    error_count++;
                    stop = 1'b1;
                end
            end
            if (got < expected && !stop)
                @(negedge clk);
        end
        plot_box = 1'b0;
        black    = 1'b0;
    endtask

    task automatic watch_for_strobes(input int cycles, output int seen);
        seen = 0;
        repeat (cycles)
        begin
            @(negedge clk);
            if (plot)
                seen++;
        end
    endtask

    task automatic run_entry(input int n);
        entry_t e;
        bit     started;
        int     got;
        int     extra;
        int     errors_before;
        e             = entries[n];
        errors_before = error_count;
        got           = 0;
        extra         = 0;
        if (e.op == OP_BOX)
            press_box(e.x_sw, e.y_sw, e.colour);
        else
            press_clear(e.x_sw, e.colour);
        wait_first_plot(started);
        if (started)
            receive_pixels(e.exp_rect, e.disturb, got);
        watch_for_strobes(AFTER_WATCH, extra);  // nothing may follow the sweep
        check_count(got + extra, int'(e.exp_rect.width) * int'(e.exp_rect.height));
        if (error_count == errors_before)
            pass_count++;
        else
            fail_count++;
        $display("test %0d: %s origin (%0d,%0d) size %0dx%0d colour %0d, %0d strobes, %s",
                 n, (e.op == OP_BOX) ? "box" : "clear", e.exp_rect.x, e.exp_rect.y,
                 e.exp_rect.width, e.exp_rect.height, e.exp_rect.colour, got + extra,
                 (error_count == errors_before) ? "ok" : "failed");
    endtask

    initial
    begin
        int quiet_strobes;
        int errors_before;
        clk       = 1'b0;
        resetn    = 1'b0;
        load_x    = 1'b0;
        plot_box  = 1'b0;
        black     = 1'b0;
        colour_in = '0;
        xy_coord  = '0;

        // op, x sw, y sw, colour, disturb, then expected x, y, w, h, colour
        entries[0] = make_entry(OP_BOX,   10,  20, 5, 1'b0,  10,  20,   4,   4, 5);
        entries[1] = make_entry(OP_BOX,   30, 125, 3, 1'b0,  30, 116,   4,   4, 3);  // clamped
        entries[2] = make_entry(OP_BOX,  127, 116, 7, 1'b0, 127, 116,   4,   4, 7);  // edge
        entries[3] = make_entry(OP_CLEAR, 55,  99, 6, 1'b0,   0,   0, 160, 120, 0);
        entries[4] = make_entry(OP_BOX,  100,  50, 6, 1'b1, 100,  50,   4,   4, 6);

        repeat (5) @(negedge clk);
        resetn = 1'b1;

        // idle after reset, no strobes without a button
        errors_before = error_count;
        watch_for_strobes(RESET_WATCH, quiet_strobes);
        check_count(quiet_strobes, 0);
        if (error_count == errors_before)
            pass_count++;
        else
            fail_count++;
        $display("test reset: %0d strobes in %0d idle cycles, %s", quiet_strobes, RESET_WATCH,
                 (error_count == errors_before) ? "ok" : "failed");

        for (int i = 0; i < NUM_ENTRIES; i++)
            run_entry(i);

        $display("tests passed: %0d, failed: %0d, errors: %0d", pass_count, fail_count,
                 error_count);
        if (error_count == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
